/* src/fabric_cfg.svh */
// Fabric configuration macros
`ifndef FABRIC_CFG_SVH
`define FABRIC_CFG_SVH

// Bus widths
`define FABRIC_ADDR_W 32
`define FABRIC_DATA_W 32
`define FABRIC_ID_W 8
// Beats minus one, as AxLEN
`define FABRIC_LEN_W 8

// Address tag field, inclusive bit positions
`define FABRIC_TAG_MSB 19
`define FABRIC_TAG_LSB 16

// Target tags
// Data RAM, write only
`define FABRIC_TAG_DRAM 4'h1
// Platform-to-core shared RAM, write only
`define FABRIC_TAG_PTC 4'h2
// Core-to-platform shared RAM, read only
`define FABRIC_TAG_CTP 4'h3

`endif

/* src/fabric_axi_pkg.sv */
// AXI field types
`default_nettype none

`include "fabric_cfg.svh"

package fabric_axi_pkg;

  // Byte address of a burst
  typedef logic [`FABRIC_ADDR_W-1:0] addr_t;
  // One data beat
  typedef logic [`FABRIC_DATA_W-1:0] data_t;
  // One strobe bit per data byte
  typedef logic [`FABRIC_DATA_W/8-1:0] strb_t;
  typedef logic [`FABRIC_ID_W-1:0] id_t;
  // Beats minus one
  typedef logic [`FABRIC_LEN_W-1:0] len_t;
  // OKAY, EXOKAY, SLVERR, DECERR
  typedef logic [1:0] resp_t;

endpackage

`default_nettype wire

/* src/fabric_route_pkg.sv */
// Route types
`default_nettype none

`include "fabric_cfg.svh"

package fabric_route_pkg;

  // Target select field of an address
  typedef logic [`FABRIC_TAG_MSB-`FABRIC_TAG_LSB:0] tag_t;

  // One burst owns the fabric at a time
  typedef enum logic [1:0] {
    ROUTE_IDLE    = 2'd0,
    ROUTE_DRAM_WR = 2'd1,
    ROUTE_PTC_WR  = 2'd2,
    ROUTE_CTP_RD  = 2'd3
  } route_state_e;

endpackage

`default_nettype wire

/* src/fabric_route_if.sv */
// Route control interface
`timescale 1ns/1ps
`default_nettype none

interface fabric_route_if;

  // Current route, held for the whole burst
  fabric_route_pkg::route_state_e route;
  // Pulses marking the end of a burst
  logic wr_done;
  logic rd_done;
  // One-hot decodes of the route
  logic route_dram_wr;
  logic route_ptc_wr;
  logic route_ctp_rd;

  // Controller side
  modport ctrl (
    output route,
    output route_dram_wr,
    output route_ptc_wr,
    output route_ctp_rd,
    input  wr_done,
    input  rd_done
  );

  // Write switch side
  modport wr (
    input  route_dram_wr,
    input  route_ptc_wr,
    output wr_done
  );

  // Read switch side
  modport rd (
    input  route_ctp_rd,
    output rd_done
  );

endinterface

`default_nettype wire

/* src/fabric_route_ctrl.sv */
// Burst route controller
`timescale 1ns/1ps
`default_nettype none

`include "fabric_cfg.svh"

module fabric_route_ctrl (
  input  logic                  clk_i,
  input  logic                  rstn_i,
  // Upstream address requests, looked at only in idle
  input  logic                  aw_valid_i,
  input  fabric_axi_pkg::addr_t aw_addr_i,
  input  logic                  ar_valid_i,
  input  fabric_axi_pkg::addr_t ar_addr_i,
  fabric_route_if.ctrl          route
);

  // Tags cut out of the two request addresses
  fabric_route_pkg::tag_t aw_tag;
  fabric_route_pkg::tag_t ar_tag;
  // Route state register and its next value
  fabric_route_pkg::route_state_e state_q;
  fabric_route_pkg::route_state_e state_d;

  assign aw_tag = aw_addr_i[`FABRIC_TAG_MSB:`FABRIC_TAG_LSB];
  assign ar_tag = ar_addr_i[`FABRIC_TAG_MSB:`FABRIC_TAG_LSB];

  // Next route
  always_comb begin
    state_d = state_q;
    case (state_q)
      fabric_route_pkg::ROUTE_IDLE: begin
        // Data RAM write first, then shared RAM write, then read
        // An unmatched tag leaves the route idle, so it is never accepted
        if (aw_valid_i && (aw_tag == `FABRIC_TAG_DRAM)) begin
          state_d = fabric_route_pkg::ROUTE_DRAM_WR;
        end else if (aw_valid_i && (aw_tag == `FABRIC_TAG_PTC)) begin
          state_d = fabric_route_pkg::ROUTE_PTC_WR;
        end else if (ar_valid_i && (ar_tag == `FABRIC_TAG_CTP)) begin
          state_d = fabric_route_pkg::ROUTE_CTP_RD;
        end
      end
      // Write burst ends on the upstream B handshake
      fabric_route_pkg::ROUTE_DRAM_WR,
      fabric_route_pkg::ROUTE_PTC_WR: begin
        if (route.wr_done) begin
          state_d = fabric_route_pkg::ROUTE_IDLE;
        end
      end
      // Read burst ends on the last R handshake
      fabric_route_pkg::ROUTE_CTP_RD: begin
        if (route.rd_done) begin
          state_d = fabric_route_pkg::ROUTE_IDLE;
        end
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      state_q <= fabric_route_pkg::ROUTE_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Route and its one-hot decodes toward the switches
  assign route.route         = state_q;
  assign route.route_dram_wr = (state_q == fabric_route_pkg::ROUTE_DRAM_WR);
  assign route.route_ptc_wr  = (state_q == fabric_route_pkg::ROUTE_PTC_WR);
  assign route.route_ctp_rd  = (state_q == fabric_route_pkg::ROUTE_CTP_RD);

endmodule

`default_nettype wire

/* src/fabric_write_switch.sv */
// Write channel switch
`timescale 1ns/1ps
`default_nettype none

module fabric_write_switch (
  fabric_route_if.wr              route,
  // Upstream AW
  input  fabric_axi_pkg::id_t     s_awid_i,
  input  fabric_axi_pkg::addr_t   s_awaddr_i,
  input  fabric_axi_pkg::len_t    s_awlen_i,
  input  logic                    s_awvalid_i,
  output logic                    s_awready_o,
  // Upstream W
  input  fabric_axi_pkg::data_t   s_wdata_i,
  input  fabric_axi_pkg::strb_t   s_wstrb_i,
  input  logic                    s_wlast_i,
  input  logic                    s_wvalid_i,
  output logic                    s_wready_o,
  // Upstream B
  output fabric_axi_pkg::id_t     s_bid_o,
  output fabric_axi_pkg::resp_t   s_bresp_o,
  output logic                    s_bvalid_o,
  input  logic                    s_bready_i,
  // Data RAM target
  output fabric_axi_pkg::id_t     dram_awid_o,
  output fabric_axi_pkg::addr_t   dram_awaddr_o,
  output fabric_axi_pkg::len_t    dram_awlen_o,
  output logic                    dram_awvalid_o,
  input  logic                    dram_awready_i,
  output fabric_axi_pkg::data_t   dram_wdata_o,
  output fabric_axi_pkg::strb_t   dram_wstrb_o,
  output logic                    dram_wlast_o,
  output logic                    dram_wvalid_o,
  input  logic                    dram_wready_i,
  input  fabric_axi_pkg::id_t     dram_bid_i,
  input  fabric_axi_pkg::resp_t   dram_bresp_i,
  input  logic                    dram_bvalid_i,
  output logic                    dram_bready_o,
  // Platform-to-core shared RAM target
  output fabric_axi_pkg::id_t     ptc_awid_o,
  output fabric_axi_pkg::addr_t   ptc_awaddr_o,
  output fabric_axi_pkg::len_t    ptc_awlen_o,
  output logic                    ptc_awvalid_o,
  input  logic                    ptc_awready_i,
  output fabric_axi_pkg::data_t   ptc_wdata_o,
  output fabric_axi_pkg::strb_t   ptc_wstrb_o,
  output logic                    ptc_wlast_o,
  output logic                    ptc_wvalid_o,
  input  logic                    ptc_wready_i,
  input  fabric_axi_pkg::id_t     ptc_bid_i,
  input  fabric_axi_pkg::resp_t   ptc_bresp_i,
  input  logic                    ptc_bvalid_i,
  output logic                    ptc_bready_o
);

  // Data RAM side sees the burst only while routed there
  assign dram_awid_o    = route.route_dram_wr ? s_awid_i : '0;
  assign dram_awaddr_o  = route.route_dram_wr ? s_awaddr_i : '0;
  assign dram_awlen_o   = route.route_dram_wr ? s_awlen_i : '0;
  assign dram_awvalid_o = route.route_dram_wr & s_awvalid_i;
  assign dram_wdata_o   = route.route_dram_wr ? s_wdata_i : '0;
  assign dram_wstrb_o   = route.route_dram_wr ? s_wstrb_i : '0;
  assign dram_wlast_o   = route.route_dram_wr & s_wlast_i;
  assign dram_wvalid_o  = route.route_dram_wr & s_wvalid_i;
  assign dram_bready_o  = route.route_dram_wr & s_bready_i;

  // Same steering for the shared RAM side
  assign ptc_awid_o     = route.route_ptc_wr ? s_awid_i : '0;
  assign ptc_awaddr_o   = route.route_ptc_wr ? s_awaddr_i : '0;
  assign ptc_awlen_o    = route.route_ptc_wr ? s_awlen_i : '0;
  assign ptc_awvalid_o  = route.route_ptc_wr & s_awvalid_i;
  assign ptc_wdata_o    = route.route_ptc_wr ? s_wdata_i : '0;
  assign ptc_wstrb_o    = route.route_ptc_wr ? s_wstrb_i : '0;
  assign ptc_wlast_o    = route.route_ptc_wr & s_wlast_i;
  assign ptc_wvalid_o   = route.route_ptc_wr & s_wvalid_i;
  assign ptc_bready_o   = route.route_ptc_wr & s_bready_i;

  // Ready back upstream from the routed target, low in idle
  // Decodes are one-hot, so an OR of the gated terms is a mux
  assign s_awready_o = (route.route_dram_wr & dram_awready_i)
                     | (route.route_ptc_wr & ptc_awready_i);
  assign s_wready_o  = (route.route_dram_wr & dram_wready_i)
                     | (route.route_ptc_wr & ptc_wready_i);

  // B response from the routed target
  assign s_bid_o    = route.route_dram_wr ? dram_bid_i :
                      route.route_ptc_wr  ? ptc_bid_i  : '0;
  assign s_bresp_o  = route.route_dram_wr ? dram_bresp_i :
                      route.route_ptc_wr  ? ptc_bresp_i  : '0;
  assign s_bvalid_o = (route.route_dram_wr & dram_bvalid_i)
                    | (route.route_ptc_wr & ptc_bvalid_i);

  // Burst is over once upstream takes the response
  assign route.wr_done = s_bvalid_o & s_bready_i;

endmodule

`default_nettype wire

/* src/fabric_read_switch.sv */
// Read channel switch
`timescale 1ns/1ps
`default_nettype none

module fabric_read_switch (
  fabric_route_if.rd              route,
  // Upstream AR
  input  fabric_axi_pkg::id_t     s_arid_i,
  input  fabric_axi_pkg::addr_t   s_araddr_i,
  input  fabric_axi_pkg::len_t    s_arlen_i,
  input  logic                    s_arvalid_i,
  output logic                    s_arready_o,
  // Upstream R
  output fabric_axi_pkg::id_t     s_rid_o,
  output fabric_axi_pkg::data_t   s_rdata_o,
  output fabric_axi_pkg::resp_t   s_rresp_o,
  output logic                    s_rlast_o,
  output logic                    s_rvalid_o,
  input  logic                    s_rready_i,
  // Core-to-platform shared RAM target
  output fabric_axi_pkg::id_t     ctp_arid_o,
  output fabric_axi_pkg::addr_t   ctp_araddr_o,
  output fabric_axi_pkg::len_t    ctp_arlen_o,
  output logic                    ctp_arvalid_o,
  input  logic                    ctp_arready_i,
  input  fabric_axi_pkg::id_t     ctp_rid_i,
  input  fabric_axi_pkg::data_t   ctp_rdata_i,
  input  fabric_axi_pkg::resp_t   ctp_rresp_i,
  input  logic                    ctp_rlast_i,
  input  logic                    ctp_rvalid_i,
  output logic                    ctp_rready_o
);

  // AR reaches the target only in the read route
  assign ctp_arid_o    = route.route_ctp_rd ? s_arid_i : '0;
  assign ctp_araddr_o  = route.route_ctp_rd ? s_araddr_i : '0;
  assign ctp_arlen_o   = route.route_ctp_rd ? s_arlen_i : '0;
  assign ctp_arvalid_o = route.route_ctp_rd & s_arvalid_i;
  assign s_arready_o   = route.route_ctp_rd & ctp_arready_i;

  // R beats upstream, zero outside the read route
  assign s_rid_o      = route.route_ctp_rd ? ctp_rid_i : '0;
  assign s_rdata_o    = route.route_ctp_rd ? ctp_rdata_i : '0;
  assign s_rresp_o    = route.route_ctp_rd ? ctp_rresp_i : '0;
  assign s_rlast_o    = route.route_ctp_rd & ctp_rlast_i;
  assign s_rvalid_o   = route.route_ctp_rd & ctp_rvalid_i;
  assign ctp_rready_o = route.route_ctp_rd & s_rready_i;

  // Last beat taken upstream closes the burst
  // A stalled last beat keeps the route open
  assign route.rd_done = s_rvalid_o & s_rready_i & s_rlast_o;

endmodule

`default_nettype wire

/* src/bus_fabric.sv */
// AXI4 routing fabric
`timescale 1ns/1ps
`default_nettype none

module bus_fabric (
  input  logic                    clk_i,
  input  logic                    rstn_i,
  // Upstream slave side
  input  fabric_axi_pkg::id_t     s_axi_awid_i,
  input  fabric_axi_pkg::addr_t   s_axi_awaddr_i,
  input  fabric_axi_pkg::len_t    s_axi_awlen_i,
  input  logic                    s_axi_awvalid_i,
  output logic                    s_axi_awready_o,
  input  fabric_axi_pkg::data_t   s_axi_wdata_i,
  input  fabric_axi_pkg::strb_t   s_axi_wstrb_i,
  input  logic                    s_axi_wlast_i,
  input  logic                    s_axi_wvalid_i,
  output logic                    s_axi_wready_o,
  output fabric_axi_pkg::id_t     s_axi_bid_o,
  output fabric_axi_pkg::resp_t   s_axi_bresp_o,
  output logic                    s_axi_bvalid_o,
  input  logic                    s_axi_bready_i,
  input  fabric_axi_pkg::id_t     s_axi_arid_i,
  input  fabric_axi_pkg::addr_t   s_axi_araddr_i,
  input  fabric_axi_pkg::len_t    s_axi_arlen_i,
  input  logic                    s_axi_arvalid_i,
  output logic                    s_axi_arready_o,
  output fabric_axi_pkg::id_t     s_axi_rid_o,
  output fabric_axi_pkg::data_t   s_axi_rdata_o,
  output fabric_axi_pkg::resp_t   s_axi_rresp_o,
  output logic                    s_axi_rlast_o,
  output logic                    s_axi_rvalid_o,
  input  logic                    s_axi_rready_i,
  // Data RAM write master side
  output fabric_axi_pkg::id_t     dram_awid_o,
  output fabric_axi_pkg::addr_t   dram_awaddr_o,
  output fabric_axi_pkg::len_t    dram_awlen_o,
  output logic                    dram_awvalid_o,
  input  logic                    dram_awready_i,
  output fabric_axi_pkg::data_t   dram_wdata_o,
  output fabric_axi_pkg::strb_t   dram_wstrb_o,
  output logic                    dram_wlast_o,
  output logic                    dram_wvalid_o,
  input  logic                    dram_wready_i,
  input  fabric_axi_pkg::id_t     dram_bid_i,
  input  fabric_axi_pkg::resp_t   dram_bresp_i,
  input  logic                    dram_bvalid_i,
  output logic                    dram_bready_o,
  // Platform-to-core shared RAM write master side
  output fabric_axi_pkg::id_t     ptc_awid_o,
  output fabric_axi_pkg::addr_t   ptc_awaddr_o,
  output fabric_axi_pkg::len_t    ptc_awlen_o,
  output logic                    ptc_awvalid_o,
  input  logic                    ptc_awready_i,
  output fabric_axi_pkg::data_t   ptc_wdata_o,
  output fabric_axi_pkg::strb_t   ptc_wstrb_o,
  output logic                    ptc_wlast_o,
  output logic                    ptc_wvalid_o,
  input  logic                    ptc_wready_i,
  input  fabric_axi_pkg::id_t     ptc_bid_i,
  input  fabric_axi_pkg::resp_t   ptc_bresp_i,
  input  logic                    ptc_bvalid_i,
  output logic                    ptc_bready_o,
  // Core-to-platform shared RAM read master side
  output fabric_axi_pkg::id_t     ctp_arid_o,
  output fabric_axi_pkg::addr_t   ctp_araddr_o,
  output fabric_axi_pkg::len_t    ctp_arlen_o,
  output logic                    ctp_arvalid_o,
  input  logic                    ctp_arready_i,
  input  fabric_axi_pkg::id_t     ctp_rid_i,
  input  fabric_axi_pkg::data_t   ctp_rdata_i,
  input  fabric_axi_pkg::resp_t   ctp_rresp_i,
  input  logic                    ctp_rlast_i,
  input  logic                    ctp_rvalid_i,
  output logic                    ctp_rready_o
);

  // Route state and completion events shared by the three blocks
  fabric_route_if u_route_if ();

  // Picks one burst and holds it until done
  fabric_route_ctrl u_route_ctrl (
    .clk_i      (clk_i),
    .rstn_i     (rstn_i),
    .aw_valid_i (s_axi_awvalid_i),
    .aw_addr_i  (s_axi_awaddr_i),
    .ar_valid_i (s_axi_arvalid_i),
    .ar_addr_i  (s_axi_araddr_i),
    .route      (u_route_if.ctrl)
  );

  // AW, W and B steering
  // Target ports share their names with the top, so they connect by name
  fabric_write_switch u_write_switch (
    .route       (u_route_if.wr),
    .s_awid_i    (s_axi_awid_i),
    .s_awaddr_i  (s_axi_awaddr_i),
    .s_awlen_i   (s_axi_awlen_i),
    .s_awvalid_i (s_axi_awvalid_i),
    .s_awready_o (s_axi_awready_o),
    .s_wdata_i   (s_axi_wdata_i),
    .s_wstrb_i   (s_axi_wstrb_i),
    .s_wlast_i   (s_axi_wlast_i),
    .s_wvalid_i  (s_axi_wvalid_i),
    .s_wready_o  (s_axi_wready_o),
    .s_bid_o     (s_axi_bid_o),
    .s_bresp_o   (s_axi_bresp_o),
    .s_bvalid_o  (s_axi_bvalid_o),
    .s_bready_i  (s_axi_bready_i),
    .*
  );

  // AR and R steering
  fabric_read_switch u_read_switch (
    .route       (u_route_if.rd),
    .s_arid_i    (s_axi_arid_i),
    .s_araddr_i  (s_axi_araddr_i),
    .s_arlen_i   (s_axi_arlen_i),
    .s_arvalid_i (s_axi_arvalid_i),
    .s_arready_o (s_axi_arready_o),
    .s_rid_o     (s_axi_rid_o),
    .s_rdata_o   (s_axi_rdata_o),
    .s_rresp_o   (s_axi_rresp_o),
    .s_rlast_o   (s_axi_rlast_o),
    .s_rvalid_o  (s_axi_rvalid_o),
    .s_rready_i  (s_axi_rready_i),
    .*
  );

endmodule

`default_nettype wire

/* dv/tb_clk_gen.sv */
// Testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic rstn_o
);

  // 20 ns period
  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;
  end

  // Reset held low over two rising edges, released on a falling edge
  initial begin
    rstn_o = 1'b0;
    repeat (2) @(posedge clk_o);
    @(negedge clk_o);
    rstn_o = 1'b1;
  end

endmodule

`default_nettype wire

/* dv/bus_fabric_assert.sv */
// Fabric protocol assertions
`timescale 1ns/1ps
`default_nettype none

module bus_fabric_assert (
  input logic                           clk_i,
  input logic                           rstn_i,
  input fabric_route_pkg::route_state_e route_i,
  input logic                           dram_valid_i,
  input logic                           ptc_valid_i,
  input logic                           ctp_valid_i,
  input logic                           up_ready_i
);

  // Failures seen so far, read by the testbench top
  int fails = 0;

  // Only the routed target may see a valid
  a_one_target: assert property (@(posedge clk_i) disable iff (!rstn_i)
    $onehot0({dram_valid_i, ptc_valid_i, ctp_valid_i}))
    else begin
      fails++;
      $error("more than one target valid at once");
    end

  // No burst accepted upstream while idle
  a_idle_ready: assert property (@(posedge clk_i) disable iff (!rstn_i)
    (route_i == fabric_route_pkg::ROUTE_IDLE) |-> !up_ready_i)
    else begin
      fails++;
      $error("upstream ready high with route idle");
    end

  // A reset cycle leaves every target valid low
  a_reset_quiet: assert property (@(posedge clk_i)
    !rstn_i |=> !(dram_valid_i || ptc_valid_i || ctp_valid_i))
    else begin
      fails++;
      $error("target valid high right after reset");
    end

endmodule

bind bus_fabric bus_fabric_assert u_assert (
  .clk_i        (clk_i),
  .rstn_i       (rstn_i),
  .route_i      (u_route_if.route),
  .dram_valid_i (dram_awvalid_o | dram_wvalid_o),
  .ptc_valid_i  (ptc_awvalid_o | ptc_wvalid_o),
  .ctp_valid_i  (ctp_arvalid_o),
  .up_ready_i   (s_axi_awready_o | s_axi_wready_o | s_axi_arready_o)
);

`default_nettype wire

/* dv/tb_fabric_checker.sv */
// Fabric response checker
`timescale 1ns/1ps
`default_nettype none

module tb_fabric_checker (
  input logic clk_i, rstn_i,
  // Expected burst from the current data row
  input logic [3:0] exp_kind,
  input logic [1:0] exp_tgt,
  input fabric_axi_pkg::addr_t exp_addr,
  input fabric_axi_pkg::id_t exp_id,
  input fabric_axi_pkg::len_t exp_len,
  input fabric_axi_pkg::data_t exp_data,
  input fabric_axi_pkg::resp_t exp_resp,
  // Watched DUT ports
  input logic dram_awvalid_o, dram_awready_i, dram_wvalid_o, dram_wready_i, dram_wlast_o,
  input logic ptc_awvalid_o, ptc_awready_i, ptc_wvalid_o, ptc_wready_i, ptc_wlast_o,
  input fabric_axi_pkg::addr_t dram_awaddr_o, ptc_awaddr_o, ctp_araddr_o,
  input fabric_axi_pkg::id_t dram_awid_o, ptc_awid_o, ctp_arid_o, s_axi_bid_o, s_axi_rid_o,
  input fabric_axi_pkg::len_t dram_awlen_o, ptc_awlen_o, ctp_arlen_o,
  input fabric_axi_pkg::data_t dram_wdata_o, ptc_wdata_o, s_axi_rdata_o,
  input fabric_axi_pkg::strb_t dram_wstrb_o, ptc_wstrb_o,
  input fabric_axi_pkg::resp_t s_axi_bresp_o, s_axi_rresp_o,
  input logic ctp_arvalid_o, ctp_arready_i, s_axi_awready_o, s_axi_arready_o,
  input logic dram_bready_o, ptc_bready_o, ctp_rready_o, s_axi_wready_o,
  input logic s_axi_bvalid_o, s_axi_bready_i, s_axi_rvalid_o, s_axi_rready_i, s_axi_rlast_o
);

  int pass_cnt = 0;
  int fail_cnt = 0;
  int err_cnt = 0;
  // Per burst tallies
  int errs_row = 0;
  int aw_cnt = 0;
  int w_cnt = 0;
  int b_cnt = 0;
  int ar_cnt = 0;
  int r_cnt = 0;
  logic stray = 1'b0;

  // Write target picked by the expected tag
  logic sel_dram;
  logic t_awvalid, t_awready, t_wvalid, t_wready, t_wlast, t_bready;
  fabric_axi_pkg::addr_t t_awaddr;
  fabric_axi_pkg::id_t t_awid;
  fabric_axi_pkg::len_t t_awlen;
  fabric_axi_pkg::data_t t_wdata;
  fabric_axi_pkg::strb_t t_wstrb;

  assign sel_dram  = (exp_tgt == 2'd1);
  assign t_awvalid = sel_dram ? dram_awvalid_o : ptc_awvalid_o;
  assign t_awready = sel_dram ? dram_awready_i : ptc_awready_i;
  assign t_awaddr  = sel_dram ? dram_awaddr_o : ptc_awaddr_o;
  assign t_awid    = sel_dram ? dram_awid_o : ptc_awid_o;
  assign t_awlen   = sel_dram ? dram_awlen_o : ptc_awlen_o;
  assign t_wvalid  = sel_dram ? dram_wvalid_o : ptc_wvalid_o;
  assign t_wready  = sel_dram ? dram_wready_i : ptc_wready_i;
  assign t_wdata   = sel_dram ? dram_wdata_o : ptc_wdata_o;
  assign t_wstrb   = sel_dram ? dram_wstrb_o : ptc_wstrb_o;
  assign t_wlast   = sel_dram ? dram_wlast_o : ptc_wlast_o;
  assign t_bready  = sel_dram ? dram_bready_o : ptc_bready_o;

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] want);
    if (got !== want) begin
      $display("MISMATCH %s got %h expected %h", name, got, want);
      errs_row++;
      err_cnt++;
    end
  endtask

  // Handshakes sampled on the rising edge
  always @(posedge clk_i) begin
    if (rstn_i) begin
      if (t_awvalid && t_awready) begin
        check("awaddr", t_awaddr, exp_addr);
        check("awid", t_awid, exp_id);
        check("awlen", t_awlen, exp_len);
        aw_cnt++;
      end
      // Beat data is the first word plus the beat index
      if (t_wvalid && t_wready) begin
        check("wdata", t_wdata, exp_data + w_cnt);
        check("wstrb", t_wstrb, 4'b1111 >> w_cnt[1:0]);
        check("wlast", t_wlast, w_cnt == exp_len);
        // Upstream sees the beat taken in the same cycle
        check("wready", s_axi_wready_o, 1'b1);
        w_cnt++;
      end
      if (s_axi_bvalid_o && s_axi_bready_i) begin
        check("bid", s_axi_bid_o, exp_id);
        check("bresp", s_axi_bresp_o, exp_resp);
        // Response also taken from the target
        check("bready", t_bready, 1'b1);
        b_cnt++;
      end
      if (ctp_arvalid_o && ctp_arready_i) begin
        check("araddr", ctp_araddr_o, exp_addr);
        check("arid", ctp_arid_o, exp_id);
        check("arlen", ctp_arlen_o, exp_len);
        ar_cnt++;
      end
      if (s_axi_rvalid_o && s_axi_rready_i) begin
        check("rdata", s_axi_rdata_o, exp_data + r_cnt);
        check("rid", s_axi_rid_o, exp_id);
        check("rresp", s_axi_rresp_o, exp_resp);
        check("rlast", s_axi_rlast_o, r_cnt == exp_len);
        check("rready", ctp_rready_o, 1'b1);
        r_cnt++;
      end
      // Any activity away from the expected target
      if (!stray &&
          ((exp_tgt != 2'd1 && (dram_awvalid_o || dram_wvalid_o || dram_bready_o)) ||
           (exp_tgt != 2'd2 && (ptc_awvalid_o || ptc_wvalid_o || ptc_bready_o)) ||
           (exp_tgt != 2'd3 && (ctp_arvalid_o || ctp_rready_o)) ||
           (exp_tgt == 2'd0 && (s_axi_awready_o || s_axi_arready_o)))) begin
        $display("valid or ready away from the routed target at %0t", $time);
        stray = 1'b1;
      end
    end
  end

  // Closes one burst, called between edges
  task automatic report_row(input int row);
    int want_aw;
    int want_ar;
    logic ok;
    want_aw = (exp_kind == 4'd0 || exp_kind == 4'd2) ? 1 : 0;
    want_ar = (exp_kind == 4'd1) ? 1 : 0;
    ok = (errs_row == 0) && !stray;
    if (aw_cnt != want_aw || b_cnt != want_aw || w_cnt != want_aw * (exp_len + 1) ||
        ar_cnt != want_ar || r_cnt != want_ar * (exp_len + 1)) begin
      $display("row %0d handshake counts are wrong: aw %0d w %0d b %0d ar %0d r %0d",
               row, aw_cnt, w_cnt, b_cnt, ar_cnt, r_cnt);
      ok = 1'b0;
    end
    if (ok) begin
      pass_cnt++;
    end else begin
      fail_cnt++;
    end
    $display("row %0d kind %0d target %0d %s", row, exp_kind, exp_tgt,
             ok ? "passed" : "failed");
    errs_row = 0;
    aw_cnt = 0;
    w_cnt = 0;
    b_cnt = 0;
    ar_cnt = 0;
    r_cnt = 0;
    stray = 1'b0;
  endtask

endmodule

`default_nettype wire

/* dv/tb_bus_fabric.sv */
// AXI fabric testbench
`timescale 1ns/1ps
`default_nettype none

`include "fabric_cfg.svh"

module tb_bus_fabric;

  // Seven words per row
  localparam int ROWS = 10;
  localparam int COLS = 7;

  logic clk_i;
  logic rstn_i;
  logic [31:0] rows [ROWS*COLS];
  int limit = 0;
  int cycles = 0;
  logic [15:0] lfsr = 16'd56147;

  // Current row, shared with the checker
  logic [3:0] exp_kind = '0;
  logic [1:0] exp_tgt = '0;
  fabric_axi_pkg::addr_t exp_addr = '0;
  fabric_axi_pkg::id_t exp_id = '0;
  fabric_axi_pkg::len_t exp_len = '0;
  fabric_axi_pkg::data_t exp_data = '0;
  fabric_axi_pkg::resp_t exp_resp = '0;

  // DUT inputs, named as the DUT ports
  fabric_axi_pkg::id_t s_axi_awid_i = '0, s_axi_arid_i = '0, dram_bid_i = '0, ptc_bid_i = '0;
  fabric_axi_pkg::id_t ctp_rid_i = '0;
  fabric_axi_pkg::addr_t s_axi_awaddr_i = '0, s_axi_araddr_i = '0;
  fabric_axi_pkg::len_t s_axi_awlen_i = '0, s_axi_arlen_i = '0;
  fabric_axi_pkg::data_t s_axi_wdata_i = '0, ctp_rdata_i = '0;
  fabric_axi_pkg::strb_t s_axi_wstrb_i = '0;
  fabric_axi_pkg::resp_t dram_bresp_i = '0, ptc_bresp_i = '0, ctp_rresp_i = '0;
  logic s_axi_awvalid_i = 0, s_axi_wlast_i = 0, s_axi_wvalid_i = 0, s_axi_bready_i = 0;
  logic s_axi_arvalid_i = 0, s_axi_rready_i = 0;
  logic dram_awready_i = 0, dram_wready_i = 0, dram_bvalid_i = 0;
  logic ptc_awready_i = 0, ptc_wready_i = 0, ptc_bvalid_i = 0;
  logic ctp_arready_i = 0, ctp_rlast_i = 0, ctp_rvalid_i = 0;
  // DUT outputs
  fabric_axi_pkg::id_t s_axi_bid_o, s_axi_rid_o, dram_awid_o, ptc_awid_o, ctp_arid_o;
  fabric_axi_pkg::addr_t dram_awaddr_o, ptc_awaddr_o, ctp_araddr_o;
  fabric_axi_pkg::len_t dram_awlen_o, ptc_awlen_o, ctp_arlen_o;
  fabric_axi_pkg::data_t s_axi_rdata_o, dram_wdata_o, ptc_wdata_o;
  fabric_axi_pkg::strb_t dram_wstrb_o, ptc_wstrb_o;
  fabric_axi_pkg::resp_t s_axi_bresp_o, s_axi_rresp_o;
  logic s_axi_awready_o, s_axi_wready_o, s_axi_bvalid_o, s_axi_arready_o;
  logic s_axi_rlast_o, s_axi_rvalid_o;
  logic dram_awvalid_o, dram_wlast_o, dram_wvalid_o, dram_bready_o;
  logic ptc_awvalid_o, ptc_wlast_o, ptc_wvalid_o, ptc_bready_o;
  logic ctp_arvalid_o, ctp_rready_o;

  // Target model state
  logic b_pend = 1'b0;
  logic [1:0] b_tgt = '0;
  int r_left = 0;
  int r_beat = 0;
  fabric_axi_pkg::id_t r_id = '0;

  tb_clk_gen u_clk (
    .clk_o  (clk_i),
    .rstn_o (rstn_i)
  );

  bus_fabric u_dut (.*);

  tb_fabric_checker u_chk (.*);

  // Galois LFSR, one step per bit taken
  function automatic logic rand_bit();
    logic out;
    out = lfsr[0];
    lfsr = {1'b0, lfsr[15:1]} ^ (out ? 16'hB400 : 16'h0000);
    return out;
  endfunction

  // Ready three times in four
  function automatic logic draw_ready();
    logic a;
    logic b;
    a = rand_bit();
    b = rand_bit();
    return a | b;
  endfunction

  function automatic fabric_axi_pkg::strb_t beat_strobes(input int beat);
    return 4'b1111 >> (beat % 4);
  endfunction

  // Target models advance on handshakes
  always @(posedge clk_i) begin
    if (!rstn_i) begin
      b_pend <= 1'b0;
      r_left <= 0;
    end else begin
      if (dram_wvalid_o && dram_wready_i && dram_wlast_o) begin
        b_pend <= 1'b1;
        b_tgt <= 2'd1;
      end
      if (ptc_wvalid_o && ptc_wready_i && ptc_wlast_o) begin
        b_pend <= 1'b1;
        b_tgt <= 2'd2;
      end
      if ((dram_bvalid_i && dram_bready_o) || (ptc_bvalid_i && ptc_bready_o)) begin
        b_pend <= 1'b0;
      end
      if (ctp_arvalid_o && ctp_arready_i) begin
        r_left <= ctp_arlen_o + 1;
        r_beat <= 0;
        r_id <= ctp_arid_o;
      end
      if (ctp_rvalid_i && ctp_rready_o) begin
        r_left <= r_left - 1;
        r_beat <= r_beat + 1;
      end
    end
  end

  // Target outputs and random stalls, driven on the falling edge
  always @(negedge clk_i) begin
    dram_awready_i = draw_ready();
    dram_wready_i = draw_ready();
    ptc_awready_i = draw_ready();
    ptc_wready_i = draw_ready();
    ctp_arready_i = draw_ready();
    s_axi_bready_i = draw_ready();
    s_axi_rready_i = draw_ready();
    dram_bvalid_i = b_pend && (b_tgt == 2'd1);
    ptc_bvalid_i = b_pend && (b_tgt == 2'd2);
    // Target without a pending response shows inverted fields
    dram_bid_i = dram_bvalid_i ? exp_id : ~exp_id;
    ptc_bid_i = ptc_bvalid_i ? exp_id : ~exp_id;
    dram_bresp_i = dram_bvalid_i ? exp_resp : ~exp_resp;
    ptc_bresp_i = ptc_bvalid_i ? exp_resp : ~exp_resp;
    ctp_rvalid_i = (r_left != 0);
    ctp_rlast_i = (r_left == 1);
    ctp_rdata_i = exp_data + r_beat;
    ctp_rid_i = r_id;
    ctp_rresp_i = exp_resp;
  end

  task automatic write_burst(input logic with_read);
    s_axi_awid_i = exp_id;
    s_axi_awaddr_i = exp_addr;
    s_axi_awlen_i = exp_len;
    s_axi_awvalid_i = 1'b1;
    // Competing read offer on the CTP tag
    if (with_read) begin
      s_axi_arid_i = exp_id;
      s_axi_araddr_i = {exp_addr[31:20], `FABRIC_TAG_CTP, exp_addr[15:0]};
      s_axi_arlen_i = exp_len;
      s_axi_arvalid_i = 1'b1;
    end
    do @(posedge clk_i); while (!(s_axi_awvalid_i && s_axi_awready_o));
    @(negedge clk_i);
    s_axi_awvalid_i = 1'b0;
    for (int b = 0; b <= exp_len; b++) begin
      s_axi_wdata_i = exp_data + b;
      s_axi_wstrb_i = beat_strobes(b);
      s_axi_wlast_i = (b == exp_len);
      s_axi_wvalid_i = 1'b1;
      do @(posedge clk_i); while (!(s_axi_wvalid_i && s_axi_wready_o));
      @(negedge clk_i);
    end
    s_axi_wvalid_i = 1'b0;
    s_axi_wlast_i = 1'b0;
    do @(posedge clk_i); while (!(s_axi_bvalid_o && s_axi_bready_i));
    // Read offer is withdrawn before the idle route can take it
    @(negedge clk_i);
    s_axi_arvalid_i = 1'b0;
  endtask

  task automatic read_burst();
    s_axi_arid_i = exp_id;
    s_axi_araddr_i = exp_addr;
    s_axi_arlen_i = exp_len;
    s_axi_arvalid_i = 1'b1;
    do @(posedge clk_i); while (!(s_axi_arvalid_i && s_axi_arready_o));
    @(negedge clk_i);
    s_axi_arvalid_i = 1'b0;
    do @(posedge clk_i); while (!(s_axi_rvalid_o && s_axi_rready_i && s_axi_rlast_o));
  endtask

  // Unmatched tag held on both address channels, then withdrawn
  task automatic unmatched_offer();
    s_axi_awaddr_i = exp_addr;
    s_axi_araddr_i = exp_addr;
    s_axi_awvalid_i = 1'b1;
    s_axi_arvalid_i = 1'b1;
    repeat (6) @(negedge clk_i);
    s_axi_awvalid_i = 1'b0;
    s_axi_arvalid_i = 1'b0;
  endtask

  initial begin
    $readmemh("dv/fabric_testdata.hex", rows);
    for (int r = 0; r < ROWS; r++) begin
      limit += (rows[r*COLS+3] + 1) * 8 + 16;
    end
    wait (rstn_i);
    for (int r = 0; r < ROWS; r++) begin
      @(negedge clk_i);
      exp_kind = rows[r*COLS][3:0];
      exp_addr = rows[r*COLS+1];
      exp_id = rows[r*COLS+2][7:0];
      exp_len = rows[r*COLS+3][7:0];
      exp_data = rows[r*COLS+4];
      exp_resp = rows[r*COLS+5][1:0];
      exp_tgt = rows[r*COLS+6][1:0];
      case (exp_kind)
        4'd0: write_burst(1'b0);
        4'd1: read_burst();
        4'd2: write_burst(1'b1);
        default: unmatched_offer();
      endcase
      @(negedge clk_i);
      u_chk.report_row(r);
    end
    $display("rows %0d passed %0d failed %0d mismatches %0d assertion failures %0d",
             ROWS, u_chk.pass_cnt, u_chk.fail_cnt, u_chk.err_cnt, u_dut.u_assert.fails);
    if (u_chk.fail_cnt == 0 && u_chk.err_cnt == 0 && u_dut.u_assert.fails == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  // Run limit from the burst lengths
  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles > limit) begin
      $display("timeout after %0d cycles, a burst never completed", cycles);
      $display("** FAIL **");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* bus_fabric.f */
+incdir+src
src/fabric_axi_pkg.sv
src/fabric_route_pkg.sv
src/fabric_route_if.sv
src/fabric_route_ctrl.sv
src/fabric_write_switch.sv
src/fabric_read_switch.sv
src/bus_fabric.sv
dv/tb_clk_gen.sv
dv/bus_fabric_assert.sv
dv/tb_fabric_checker.sv
dv/tb_bus_fabric.sv

/* dv/fabric_testdata.hex */
// kind(0 wr, 1 rd, 2 wr with read offer, 3 unmatched) addr id len data resp target
// target: 1 data RAM, 2 platform-to-core RAM, 3 core-to-platform RAM, 0 none
0 00010000 11 03 a0000000 0 1
0 00020040 22 00 b0000000 0 2
1 00030100 33 03 c0000000 0 3
2 00010200 44 01 d0000000 1 1
0 00020300 55 07 e0000000 2 2
3 00050000 66 00 00000000 0 0
1 00030400 77 00 f0000000 2 3
0 00010500 88 0f 12340000 0 1
1 00030600 99 07 56780000 0 3
2 00020700 aa 02 9abc0000 3 2
